// ==== logic/video_params.svh ====
// screen geometry, table sizes and register map
// for the scaled-down video subsystem
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// pixels per line and lines per frame, counted from 0
`define VID_H_TOTAL   48
`define VID_H_ACTIVE  32
`define VID_V_TOTAL   24
`define VID_V_ACTIVE  16

// tile and object edge in pixels
`define VID_TILE      8

// tile map in tiles, wraps at 64x32 pixels
`define VID_MAP_W     8
`define VID_MAP_H     4
`define VID_OBJ_N     4

// control registers
`define VID_REG_HPOS  0
`define VID_REG_VPOS  1
`define VID_REG_LAYER 2

// table regions: 32 map words, 4 sprites, 16 palette entries
`define VID_MAP_BASE  8'h20
`define VID_OBJ_BASE  8'h40
`define VID_PAL_BASE  8'h80

`endif

// ==== logic/video_pkg.sv ====
// shared vector types and packed structs of the video subsystem
`default_nettype none

package video_pkg;

    typedef logic [5:0]  hpos_t;
    typedef logic [4:0]  vpos_t;
    // colour index, 0 is transparent
    typedef logic [3:0]  pxl_t;
    // red in the upper nibble, then green, then blue
    typedef logic [11:0] rgb_t;
    typedef logic [7:0]  cpu_addr_t;
    typedef logic [15:0] cpu_data_t;

    typedef struct packed {
        logic scr_en;
        logic obj_en;
        logic obj_front;
    } layer_ctrl_t;

    typedef struct packed {
        hpos_t hdump;
        vpos_t vdump;
        logic  blank;
    } raster_t;

    // table write request towards both layers
    typedef struct packed {
        logic [5:0] idx;
        cpu_data_t  data;
        logic       map_we;
        logic       obj_we;
    } tbl_wr_t;

    typedef struct packed {
        logic  spare;
        hpos_t x;
        vpos_t y;
        pxl_t  color;
    } obj_entry_t;

endpackage

`default_nettype wire

// ==== logic/video_timing.sv ====
// pixel and line counters with blanking
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module video_timing (
    input  logic                clk,
    input  logic                reset,
    input  logic                pxl_cen,
    output video_pkg::raster_t  raster
);

    video_pkg::hpos_t h_nxt;
    video_pkg::vpos_t v_nxt;
    logic             line_start;

    // last pixel of the line
    assign line_start = raster.hdump == video_pkg::hpos_t'(`VID_H_TOTAL - 1);

    always_comb begin
        v_nxt = raster.vdump;
        if (line_start) begin
            h_nxt = '0;
            if (raster.vdump == video_pkg::vpos_t'(`VID_V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = raster.vdump + 1'b1;
            end
        end else begin
            h_nxt = raster.hdump + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            raster <= '0;
        end else if (pxl_cen) begin
            raster.hdump <= h_nxt;
            raster.vdump <= v_nxt;
            // blank follows the position it is stored with
            raster.blank <= (h_nxt >= video_pkg::hpos_t'(`VID_H_ACTIVE)) ||
                            (v_nxt >= video_pkg::vpos_t'(`VID_V_ACTIVE));
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_mmr.sv ====
// CPU register block with scroll and layer control
// and write decoding for map, object and palette tables
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module video_mmr (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cpu_we,
    input  video_pkg::cpu_addr_t     cpu_addr,
    input  video_pkg::cpu_data_t     cpu_data,
    output video_pkg::cpu_data_t     mmr_dout,
    output video_pkg::hpos_t         hpos,
    output video_pkg::vpos_t         vpos,
    output video_pkg::layer_ctrl_t   layer_ctrl,
    output video_pkg::tbl_wr_t       tbl_wr,
    output logic                     pal_we,
    output video_pkg::pxl_t          pal_idx,
    output video_pkg::rgb_t          pal_data
);

    localparam int MAP_N = `VID_MAP_W * `VID_MAP_H;
    localparam int PAL_N = 2 ** $bits(video_pkg::pxl_t);

    video_pkg::cpu_addr_t map_off;
    video_pkg::cpu_addr_t obj_off;
    video_pkg::cpu_addr_t pal_off;
    logic                 map_hit;
    logic                 obj_hit;
    logic                 pal_hit;
    logic                 map_we_q;
    logic                 obj_we_q;
    logic [5:0]           idx_q;
    video_pkg::cpu_data_t data_q;

    // region relative offsets
    assign map_off = cpu_addr - `VID_MAP_BASE;
    assign obj_off = cpu_addr - `VID_OBJ_BASE;
    assign pal_off = cpu_addr - `VID_PAL_BASE;

    assign map_hit = cpu_addr >= `VID_MAP_BASE && map_off < video_pkg::cpu_addr_t'(MAP_N);
    assign obj_hit = cpu_addr >= `VID_OBJ_BASE && obj_off < video_pkg::cpu_addr_t'(`VID_OBJ_N);
    assign pal_hit = cpu_addr >= `VID_PAL_BASE && pal_off < video_pkg::cpu_addr_t'(PAL_N);

    always_ff @(posedge clk) begin
        if (reset) begin
            hpos       <= '0;
            vpos       <= '0;
            layer_ctrl <= '0;
            map_we_q   <= 1'b0;
            obj_we_q   <= 1'b0;
            pal_we     <= 1'b0;
        end else begin
            if (cpu_we && cpu_addr == video_pkg::cpu_addr_t'(`VID_REG_HPOS)) begin
                hpos <= cpu_data[5:0];
            end
            if (cpu_we && cpu_addr == video_pkg::cpu_addr_t'(`VID_REG_VPOS)) begin
                vpos <= cpu_data[4:0];
            end
            if (cpu_we && cpu_addr == video_pkg::cpu_addr_t'(`VID_REG_LAYER)) begin
                layer_ctrl <= video_pkg::layer_ctrl_t'(cpu_data[2:0]);
            end
            // single cycle strobes, one destination each
            map_we_q <= cpu_we && map_hit;
            obj_we_q <= cpu_we && obj_hit;
            pal_we   <= cpu_we && pal_hit;
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        idx_q    <= map_hit ? map_off[5:0] : obj_off[5:0];
        data_q   <= cpu_data;
        pal_idx  <= pal_off[3:0];
        pal_data <= cpu_data[11:0];
    end

    assign tbl_wr = '{idx: idx_q, data: data_q, map_we: map_we_q, obj_we: obj_we_q};

    // readback, zero outside the control registers
    always_comb begin
        mmr_dout = '0;
        case (cpu_addr)
            video_pkg::cpu_addr_t'(`VID_REG_HPOS):  mmr_dout = video_pkg::cpu_data_t'(hpos);
            video_pkg::cpu_addr_t'(`VID_REG_VPOS):  mmr_dout = video_pkg::cpu_data_t'(vpos);
            video_pkg::cpu_addr_t'(`VID_REG_LAYER): mmr_dout = video_pkg::cpu_data_t'(layer_ctrl);
            default:                                mmr_dout = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/video_tilemap.sv ====
// scrolling tile layer with internal tile map
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module video_tilemap (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pxl_cen,
    input  video_pkg::raster_t   raster,
    input  video_pkg::hpos_t     hpos,
    input  video_pkg::vpos_t     vpos,
    input  video_pkg::tbl_wr_t   tbl_wr,
    output video_pkg::pxl_t      scr_pxl
);

    localparam int MAP_N  = `VID_MAP_W * `VID_MAP_H;
    localparam int MAP_AW = $clog2(MAP_N);

    video_pkg::pxl_t     map_mem [MAP_N];
    video_pkg::hpos_t    scr_x;
    video_pkg::vpos_t    scr_y;
    logic [MAP_AW-1:0]   tile_idx;

    // map is 64x32 pixels so the sums wrap by width
    assign scr_x = raster.hdump + hpos;
    assign scr_y = raster.vdump + vpos;

    // row major, MAP_W tiles per row
    assign tile_idx = MAP_AW'((scr_y / `VID_TILE) * `VID_MAP_W + scr_x / `VID_TILE);

    // table writes are not tied to the pixel enable
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MAP_N; i++) begin
                map_mem[i] <= '0;
            end
        end else if (tbl_wr.map_we) begin
            map_mem[tbl_wr.idx[MAP_AW-1:0]] <= tbl_wr.data[3:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scr_pxl <= '0;
        end else if (pxl_cen) begin
            // solid colour per tile
            scr_pxl <= map_mem[tile_idx];
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_obj.sv ====
// object layer, four fixed-size solid sprites
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module video_obj (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pxl_cen,
    input  video_pkg::raster_t   raster,
    input  video_pkg::tbl_wr_t   tbl_wr,
    output video_pkg::pxl_t      obj_pxl
);

    localparam int OBJ_AW = $clog2(`VID_OBJ_N);

    video_pkg::obj_entry_t  obj_tbl [`VID_OBJ_N];
    logic [`VID_OBJ_N-1:0]  hit;
    video_pkg::pxl_t        obj_col;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `VID_OBJ_N; i++) begin
                obj_tbl[i] <= '0;
            end
        end else if (tbl_wr.obj_we) begin
            obj_tbl[tbl_wr.idx[OBJ_AW-1:0]] <= video_pkg::obj_entry_t'(tbl_wr.data);
        end
    end

    // box test without wrap, one bit wider so x+8 cannot overflow
    always_comb begin
        for (int i = 0; i < `VID_OBJ_N; i++) begin
            hit[i] = (raster.hdump >= obj_tbl[i].x) &&
                     ({1'b0, raster.hdump} < {1'b0, obj_tbl[i].x} + 7'(`VID_TILE)) &&
                     (raster.vdump >= obj_tbl[i].y) &&
                     ({1'b0, raster.vdump} < {1'b0, obj_tbl[i].y} + 6'(`VID_TILE));
        end
    end

    // walk from the top entry down so the lowest index wins
    always_comb begin
        obj_col = '0;
        for (int i = `VID_OBJ_N - 1; i >= 0; i--) begin
            if (hit[i] && obj_tbl[i].color != '0) begin
                obj_col = obj_tbl[i].color;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            obj_pxl <= '0;
        end else if (pxl_cen) begin
            obj_pxl <= obj_col;
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_colmix.sv ====
// layer priority, palette lookup and blanking
`timescale 1ns/1ps
`default_nettype none

module video_colmix (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     pxl_cen,
    input  video_pkg::raster_t       raster,
    input  video_pkg::layer_ctrl_t   layer_ctrl,
    input  video_pkg::pxl_t          scr_pxl,
    input  video_pkg::pxl_t          obj_pxl,
    input  logic                     pal_we,
    input  video_pkg::pxl_t          pal_idx,
    input  video_pkg::rgb_t          pal_data,
    output video_pkg::rgb_t          rgb,
    output logic                     blank_dly
);

    localparam int PAL_N = 2 ** $bits(video_pkg::pxl_t);

    video_pkg::rgb_t  pal_mem [PAL_N];
    video_pkg::pxl_t  scr_m;
    video_pkg::pxl_t  obj_m;
    video_pkg::pxl_t  sel;
    logic             blank_d1;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PAL_N; i++) begin
                pal_mem[i] <= '0;
            end
        end else if (pal_we) begin
            pal_mem[pal_idx] <= pal_data;
        end
    end

    // disabled layers look transparent
    assign scr_m = layer_ctrl.scr_en ? scr_pxl : '0;
    assign obj_m = layer_ctrl.obj_en ? obj_pxl : '0;

    always_comb begin
        if (layer_ctrl.obj_front) begin
            sel = (obj_m != '0) ? obj_m : scr_m;
        end else begin
            sel = (scr_m != '0) ? scr_m : obj_m;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            blank_d1  <= 1'b1;
            blank_dly <= 1'b1;
            rgb       <= '0;
        end else if (pxl_cen) begin
            // blank_d1 matches the raster the layers just used
            blank_d1  <= raster.blank;
            blank_dly <= blank_d1;
            rgb       <= blank_d1 ? '0 : pal_mem[sel];
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_top.sv ====
// video subsystem top level
// timing, registers, tile and object layers, colour mixer
`timescale 1ns/1ps
`default_nettype none

module video_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pxl_cen,
    input  logic                  cpu_we,
    input  video_pkg::cpu_addr_t  cpu_addr,
    input  video_pkg::cpu_data_t  cpu_data,
    output video_pkg::cpu_data_t  mmr_dout,
    output video_pkg::raster_t    raster,
    output video_pkg::rgb_t       rgb,
    output logic                  blank_dly
);

    video_pkg::hpos_t        hpos;
    video_pkg::vpos_t        vpos;
    video_pkg::layer_ctrl_t  layer_ctrl;
    video_pkg::tbl_wr_t      tbl_wr;
    logic                    pal_we;
    video_pkg::pxl_t         pal_idx;
    video_pkg::rgb_t         pal_data;
    video_pkg::pxl_t         scr_pxl;
    video_pkg::pxl_t         obj_pxl;

    video_timing u_timing (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .pxl_cen    ( pxl_cen     ),
        .raster     ( raster      )
    );

    video_mmr u_mmr (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .cpu_we     ( cpu_we      ),
        .cpu_addr   ( cpu_addr    ),
        .cpu_data   ( cpu_data    ),
        .mmr_dout   ( mmr_dout    ),
        .hpos       ( hpos        ),
        .vpos       ( vpos        ),
        .layer_ctrl ( layer_ctrl  ),
        .tbl_wr     ( tbl_wr      ),
        .pal_we     ( pal_we      ),
        .pal_idx    ( pal_idx     ),
        .pal_data   ( pal_data    )
    );

    video_tilemap u_scroll (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .pxl_cen    ( pxl_cen     ),
        .raster     ( raster      ),
        .hpos       ( hpos        ),
        .vpos       ( vpos        ),
        .tbl_wr     ( tbl_wr      ),
        .scr_pxl    ( scr_pxl     )
    );

    video_obj u_obj (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .pxl_cen    ( pxl_cen     ),
        .raster     ( raster      ),
        .tbl_wr     ( tbl_wr      ),
        .obj_pxl    ( obj_pxl     )
    );

    video_colmix u_colmix (
        .clk        ( clk         ),
        .reset      ( reset       ),
        .pxl_cen    ( pxl_cen     ),
        .raster     ( raster      ),
        .layer_ctrl ( layer_ctrl  ),
        .scr_pxl    ( scr_pxl     ),
        .obj_pxl    ( obj_pxl     ),
        .pal_we     ( pal_we      ),
        .pal_idx    ( pal_idx     ),
        .pal_data   ( pal_data    ),
        .rgb        ( rgb         ),
        .blank_dly  ( blank_dly   )
    );

endmodule

`default_nettype wire

// ==== testbench/video_tb.sv ====
// testbench for the video subsystem top level
// random CPU writes in vertical blanking, frame model with a two-tick raster history
`timescale 1ns/1ps
`default_nettype none
`include "video_params.svh"

module video_tb;

    localparam int MAP_N = `VID_MAP_W * `VID_MAP_H;
    localparam int PAL_N = 16;
    localparam int WAIT_LIMIT = 2 * `VID_H_TOTAL * `VID_V_TOTAL + 200;

    logic                   clk;
    logic                   reset;
    logic                   pxl_cen;
    logic                   cpu_we;
    video_pkg::cpu_addr_t   cpu_addr;
    video_pkg::cpu_data_t   cpu_data;
    video_pkg::cpu_data_t   mmr_dout;
    video_pkg::raster_t     raster;
    video_pkg::rgb_t        rgb;
    logic                   blank_dly;

    // model state
    video_pkg::pxl_t        m_map [MAP_N];
    video_pkg::rgb_t        m_pal [PAL_N];
    video_pkg::hpos_t       m_obj_x [`VID_OBJ_N];
    video_pkg::vpos_t       m_obj_y [`VID_OBJ_N];
    video_pkg::pxl_t        m_obj_c [`VID_OBJ_N];
    video_pkg::hpos_t       m_hpos;
    video_pkg::vpos_t       m_vpos;
    video_pkg::layer_ctrl_t m_ctrl;
    video_pkg::raster_t     model_r;
    video_pkg::raster_t     hist1;
    video_pkg::raster_t     hist2;
    logic                   armed;
    logic                   ticked;
    string                  test_name;

    video_top u_video_top (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .cpu_we    ( cpu_we    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_data  ( cpu_data  ),
        .mmr_dout  ( mmr_dout  ),
        .raster    ( raster    ),
        .rgb       ( rgb       ),
        .blank_dly ( blank_dly )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input string exp, input string act);
        $display("FAILED %s: expected %s, actual %s", name, exp, act);
        $display("Test failed");
        $fatal(1, "value mismatch in %s", name);
    endtask

    task automatic check_data(input string name, input video_pkg::cpu_data_t exp,
                              input video_pkg::cpu_data_t act);
        if (exp !== act) begin
            report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
        end
    endtask

    task automatic check_raster(input string name, input video_pkg::raster_t exp,
                                input video_pkg::raster_t act);
        if (exp !== act) begin
            report_mismatch(name,
                $sformatf("h=%0d v=%0d blank=%b", exp.hdump, exp.vdump, exp.blank),
                $sformatf("h=%0d v=%0d blank=%b", act.hdump, act.vdump, act.blank));
        end
    endtask

    task automatic check_rgb(input string name, input video_pkg::rgb_t exp,
                             input video_pkg::rgb_t act);
        if (exp !== act) begin
            report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
        end
    endtask

    // next raster position with blank from the active limits
    function automatic video_pkg::raster_t advance_raster(video_pkg::raster_t r);
        video_pkg::raster_t n;
        int h;
        int v;
        h = int'(r.hdump) + 1;
        v = int'(r.vdump);
        if (h == `VID_H_TOTAL) begin
            h = 0;
            v = v + 1;
            if (v == `VID_V_TOTAL) begin
                v = 0;
            end
        end
        n.hdump = video_pkg::hpos_t'(h);
        n.vdump = video_pkg::vpos_t'(v);
        n.blank = (h >= `VID_H_ACTIVE) || (v >= `VID_V_ACTIVE);
        return n;
    endfunction

    // colour of a visible position from the model tables
    function automatic video_pkg::rgb_t expected_rgb(video_pkg::raster_t r);
        int sx;
        int sy;
        int h;
        int v;
        int i;
        video_pkg::pxl_t scr;
        video_pkg::pxl_t obj;
        video_pkg::pxl_t idx;
        h = int'(r.hdump);
        v = int'(r.vdump);
        sx = (h + int'(m_hpos)) % (`VID_MAP_W * `VID_TILE);
        sy = (v + int'(m_vpos)) % (`VID_MAP_H * `VID_TILE);
        scr = m_map[(sy / `VID_TILE) * `VID_MAP_W + sx / `VID_TILE];
        obj = '0;
        for (i = 0; i < `VID_OBJ_N; i++) begin
            // first covering sprite with a colour claims the pixel
            if (obj == '0 && h >= int'(m_obj_x[i]) && h < int'(m_obj_x[i]) + `VID_TILE &&
                v >= int'(m_obj_y[i]) && v < int'(m_obj_y[i]) + `VID_TILE) begin
                obj = m_obj_c[i];
            end
        end
        if (!m_ctrl.scr_en) begin
            scr = '0;
        end
        if (!m_ctrl.obj_en) begin
            obj = '0;
        end
        if (m_ctrl.obj_front) begin
            idx = (obj != '0) ? obj : scr;
        end else begin
            idx = (scr != '0) ? scr : obj;
        end
        return m_pal[idx];
    endfunction

    // one clock with the history checks on each tick
    task automatic clock_step();
        logic was_tick;
        @(posedge clk);
        was_tick = pxl_cen;
        #1;
        pxl_cen = ~pxl_cen;
        ticked = was_tick;
        if (armed) begin
            if (was_tick) begin
                check_flag("blank_dly", hist2.blank, blank_dly);
                if (hist2.blank) begin
                    check_rgb("blanking", '0, rgb);
                end else begin
                    check_rgb(test_name, expected_rgb(hist2), rgb);
                end
                hist2 = hist1;
                model_r = advance_raster(model_r);
                hist1 = model_r;
            end
            check_raster("timing", model_r, raster);
        end
    endtask

    task automatic write_word(input video_pkg::cpu_addr_t addr, input video_pkg::cpu_data_t data);
        cpu_we = 1'b1;
        cpu_addr = addr;
        cpu_data = data;
        clock_step();
        cpu_we = 1'b0;
    endtask

    task automatic read_check(input video_pkg::cpu_addr_t addr, input video_pkg::cpu_data_t exp);
        cpu_addr = addr;
        #1;
        check_data(test_name, exp, mmr_dout);
        clock_step();
    endtask

    task automatic wait_vblank_start();
        int n;
        n = 0;
        clock_step();
        while (!(ticked && raster.vdump == video_pkg::vpos_t'(`VID_V_ACTIVE) &&
                 raster.hdump == '0)) begin
            n++;
            if (n > WAIT_LIMIT) begin
                $display("Test failed");
                $fatal(1, "timeout, the raster never reached the first vertical blanking line");
            end
            clock_step();
        end
    endtask

    task automatic run_frames(input int n);
        repeat (n) begin
            wait_vblank_start();
        end
    endtask

    task automatic set_regs(input video_pkg::hpos_t h, input video_pkg::vpos_t v,
                            input video_pkg::layer_ctrl_t c);
        m_hpos = h;
        m_vpos = v;
        m_ctrl = c;
        write_word(video_pkg::cpu_addr_t'(`VID_REG_HPOS), {10'b0, h});
        write_word(video_pkg::cpu_addr_t'(`VID_REG_VPOS), {11'b0, v});
        write_word(video_pkg::cpu_addr_t'(`VID_REG_LAYER), {13'b0, c});
    endtask

    task automatic load_tables();
        video_pkg::cpu_data_t d;
        int i;
        for (i = 0; i < MAP_N; i++) begin
            d = video_pkg::cpu_data_t'($urandom);
            m_map[i] = d[3:0];
            write_word(`VID_MAP_BASE + video_pkg::cpu_addr_t'(i), d);
        end
        for (i = 0; i < PAL_N; i++) begin
            d = video_pkg::cpu_data_t'($urandom);
            m_pal[i] = d[11:0];
            write_word(`VID_PAL_BASE + video_pkg::cpu_addr_t'(i), d);
        end
        // sprites packed near the visible area so they often overlap
        for (i = 0; i < `VID_OBJ_N; i++) begin
            m_obj_x[i] = video_pkg::hpos_t'($urandom % 36);
            m_obj_y[i] = video_pkg::vpos_t'($urandom % 18);
            m_obj_c[i] = video_pkg::pxl_t'($urandom % 16);
            write_word(`VID_OBJ_BASE + video_pkg::cpu_addr_t'(i),
                       {1'b0, m_obj_x[i], m_obj_y[i], m_obj_c[i]});
        end
    endtask

    task automatic readback_test();
        video_pkg::cpu_data_t d;
        video_pkg::cpu_addr_t a;
        int i;
        test_name = "readback";
        wait_vblank_start();
        d = video_pkg::cpu_data_t'($urandom);
        m_hpos = d[5:0];
        write_word(video_pkg::cpu_addr_t'(`VID_REG_HPOS), d);
        read_check(video_pkg::cpu_addr_t'(`VID_REG_HPOS), d & 16'h003f);
        d = video_pkg::cpu_data_t'($urandom);
        m_vpos = d[4:0];
        write_word(video_pkg::cpu_addr_t'(`VID_REG_VPOS), d);
        read_check(video_pkg::cpu_addr_t'(`VID_REG_VPOS), d & 16'h001f);
        d = video_pkg::cpu_data_t'($urandom);
        m_ctrl = video_pkg::layer_ctrl_t'(d[2:0]);
        write_word(video_pkg::cpu_addr_t'(`VID_REG_LAYER), d);
        read_check(video_pkg::cpu_addr_t'(`VID_REG_LAYER), d & 16'h0007);
        for (i = 0; i < 24; i++) begin
            a = video_pkg::cpu_addr_t'(3 + $urandom % 253);
            read_check(a, '0);
        end
    endtask

    initial begin
        reset = 1'b1;
        pxl_cen = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        armed = 1'b0;
        ticked = 1'b0;
        test_name = "reset";
        void'($urandom(32'h40973ceb));
        for (int i = 0; i < MAP_N; i++) begin
            m_map[i] = '0;
        end
        for (int i = 0; i < PAL_N; i++) begin
            m_pal[i] = '0;
        end
        for (int i = 0; i < `VID_OBJ_N; i++) begin
            m_obj_x[i] = '0;
            m_obj_y[i] = '0;
            m_obj_c[i] = '0;
        end
        m_hpos = '0;
        m_vpos = '0;
        m_ctrl = '0;
        repeat (5) begin
            clock_step();
        end
        reset = 1'b0;
        model_r = '0;
        hist1 = '0;
        hist2 = '0;
        hist2.blank = 1'b1;
        check_raster("reset raster", model_r, raster);
        check_rgb("reset rgb", '0, rgb);
        check_flag("reset blank_dly", 1'b1, blank_dly);
        check_data("reset hpos register", '0, mmr_dout);
        armed = 1'b1;

        // timing through two full frames with both layers off
        test_name = "timing";
        run_frames(3);

        readback_test();

        test_name = "scroll layer";
        wait_vblank_start();
        load_tables();
        set_regs(video_pkg::hpos_t'($urandom), video_pkg::vpos_t'($urandom), 3'b100);
        run_frames(2);

        test_name = "object layer";
        wait_vblank_start();
        load_tables();
        set_regs(video_pkg::hpos_t'($urandom), video_pkg::vpos_t'($urandom), 3'b010);
        run_frames(2);

        test_name = "objects in front";
        wait_vblank_start();
        load_tables();
        set_regs(video_pkg::hpos_t'($urandom), video_pkg::vpos_t'($urandom), 3'b111);
        run_frames(2);

        test_name = "scroll in front";
        wait_vblank_start();
        set_regs(m_hpos, m_vpos, 3'b110);
        run_frames(2);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/video_pkg.sv
logic/video_timing.sv
logic/video_mmr.sv
logic/video_tilemap.sv
logic/video_obj.sv
logic/video_colmix.sv
logic/video_top.sv
testbench/video_tb.sv

// ==== Bender.yml ====
package:
  name: video_subsystem

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/video_pkg.sv
      - logic/video_timing.sv
      - logic/video_mmr.sv
      - logic/video_tilemap.sv
      - logic/video_obj.sv
      - logic/video_colmix.sv
      - logic/video_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/video_tb.sv
